// File: common/bsc_pkg.sv
`default_nettype none

package bsc_pkg;

   localparam int xlen = 32;
   localparam int cnt_w = 5;

   localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
   localparam logic [xlen-1:0] nop_incr = 32'd4;

   // RV32I major opcodes handled by the core
   localparam logic [6:0] opc_reg    = 7'b0110011;
   localparam logic [6:0] opc_imm    = 7'b0010011;
   localparam logic [6:0] opc_lui    = 7'b0110111;
   localparam logic [6:0] opc_jal    = 7'b1101111;
   localparam logic [6:0] opc_branch = 7'b1100011;
   localparam logic [6:0] opc_store  = 7'b0100011;

   typedef enum logic [2:0] {
      cls_alu_reg,
      cls_alu_imm,
      cls_lui,
      cls_jal,
      cls_branch,
      cls_store,
      cls_nop
   } op_class_e;

   typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor} alu_op_e;

   typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_type_e;

   typedef enum logic [1:0] {rd_from_alu, rd_from_link, rd_from_imm} rd_src_e;

   typedef enum logic [1:0] {st_fetch, st_compare, st_exec, st_store} seq_state_e;

endpackage

`default_nettype wire

// File: decoder/bsc_decode.sv
`timescale 1ns/1ps
`default_nettype none

module bsc_decode (
   input  wire                      clk,
   input  wire  [bsc_pkg::xlen-1:0] i_rdt,
   input  wire                      i_en,
   output bsc_pkg::op_class_e       o_class,
   output bsc_pkg::alu_op_e         o_alu_op,
   output logic                     o_op_b_imm,
   output logic                     o_bne,
   output bsc_pkg::rd_src_e         o_rd_src,
   output logic [4:0]               o_rd_addr,
   output logic [4:0]               o_rs1_addr,
   output logic [4:0]               o_rs2_addr
);
   import bsc_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic f3_ok;
   alu_op_e f3_op;
   op_class_e cls_d;
   alu_op_e op_d;
   logic b_imm_d;
   rd_src_e src_d;

   assign opcode = i_rdt[6:0];
   assign funct3 = i_rdt[14:12];
   assign funct7 = i_rdt[31:25];

   // funct3 map shared by register and immediate forms
   always_comb begin
      f3_ok = 1'b1;
      case (funct3)
         3'b000: f3_op = alu_add;
         3'b100: f3_op = alu_xor;
         3'b110: f3_op = alu_or;
         3'b111: f3_op = alu_and;
         default: begin
            f3_op = alu_add;
            f3_ok = 1'b0;
         end
      endcase
   end

   always_comb begin
      cls_d = cls_nop;
      op_d = alu_add;
      b_imm_d = 1'b0;
      src_d = rd_from_alu;
      case (opcode)
         opc_reg: begin
            if (f3_ok && funct7 == 7'b0000000) begin
               cls_d = cls_alu_reg;
               op_d = f3_op;
            end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
               cls_d = cls_alu_reg;
               op_d = alu_sub;
            end
         end
         opc_imm: begin
            if (f3_ok) begin
               cls_d = cls_alu_imm;
               op_d = f3_op;
               b_imm_d = 1'b1;
            end
         end
         opc_lui: begin
            cls_d = cls_lui;
            src_d = rd_from_imm;
         end
         opc_jal: begin
            cls_d = cls_jal;
            src_d = rd_from_link;
         end
         opc_branch: begin
            if (funct3[2:1] == 2'b00) begin
               cls_d = cls_branch;
            end
         end
         opc_store: begin
            // Word stores only, address is rs1 + imm through the adder
            if (funct3 == 3'b010) begin
               cls_d = cls_store;
               b_imm_d = 1'b1;
            end
         end
         default: cls_d = cls_nop;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_en) begin
         o_class <= cls_d;
         o_alu_op <= op_d;
         o_op_b_imm <= b_imm_d;
         o_bne <= funct3[0];
         o_rd_src <= src_d;
         o_rd_addr <= i_rdt[11:7];
         o_rs1_addr <= i_rdt[19:15];
         o_rs2_addr <= i_rdt[24:20];
      end
   end

endmodule

`default_nettype wire

// File: decoder/bsc_immdec.sv
`timescale 1ns/1ps
`default_nettype none

module bsc_immdec (
   input  wire                       clk,
   input  wire  [bsc_pkg::xlen-1:0]  i_rdt,
   input  wire                       i_en,
   input  wire  [bsc_pkg::cnt_w-1:0] i_cnt,
   output logic                      o_imm
);
   import bsc_pkg::*;

   imm_type_e imm_type;
   logic [xlen-1:0] imm_d;
   logic [xlen-1:0] imm_q;

   always_comb begin
      case (i_rdt[6:0])
         opc_store:  imm_type = imm_s;
         opc_branch: imm_type = imm_b;
         opc_lui:    imm_type = imm_u;
         opc_jal:    imm_type = imm_j;
         default:    imm_type = imm_i;
      endcase
   end

   // Sign always comes from bit 31
   always_comb begin
      case (imm_type)
         imm_s: imm_d = {{20{i_rdt[31]}}, i_rdt[31:25], i_rdt[11:7]};
         imm_b: imm_d = {{19{i_rdt[31]}}, i_rdt[31], i_rdt[7], i_rdt[30:25], i_rdt[11:8], 1'b0};
         imm_u: imm_d = {i_rdt[31:12], 12'h000};
         imm_j: imm_d = {{11{i_rdt[31]}}, i_rdt[31], i_rdt[19:12], i_rdt[20], i_rdt[30:21], 1'b0};
         default: imm_d = {{20{i_rdt[31]}}, i_rdt[31:20]};
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_en) begin
         imm_q <= imm_d;
      end
   end

   assign o_imm = imm_q[i_cnt];

endmodule

`default_nettype wire

// File: design/bsc_alu.sv
`timescale 1ns/1ps
`default_nettype none

module bsc_alu (
   input  wire                       clk,
   input  wire                       i_rst_n,
   input  wire  [bsc_pkg::cnt_w-1:0] i_cnt,
   input  wire                       i_active,
   input  wire                       i_rs1,
   input  wire                       i_rs2,
   input  wire                       i_imm,
   input  wire                       i_op_b_imm,
   input  wire  bsc_pkg::alu_op_e    i_op,
   output logic                      o_rd,
   output logic                      o_eq
);
   import bsc_pkg::*;

   logic carry_q;
   logic eq_q;
   logic first;
   logic sub;
   logic op_b;
   logic b_eff;
   logic c_in;
   logic sum;

   assign first = i_cnt == '0;
   assign sub = i_op == alu_sub;
   assign op_b = i_op_b_imm ? i_imm : i_rs2;

   // Subtract as rs1 + ~b + 1, the +1 coming from the preset carry
   assign b_eff = op_b ^ sub;
   assign c_in = first ? sub : carry_q;
   assign sum = i_rs1 ^ b_eff ^ c_in;

   // Includes the current bit, so at count 31 it covers the whole word
   assign o_eq = (i_rs1 ~^ op_b) & (first | eq_q);

   always_comb begin
      case (i_op)
         alu_and: o_rd = i_rs1 & op_b;
         alu_or:  o_rd = i_rs1 | op_b;
         alu_xor: o_rd = i_rs1 ^ op_b;
         default: o_rd = sum;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
         eq_q <= 1'b0;
      end else if (i_active) begin
         carry_q <= (i_rs1 & b_eff) | (c_in & (i_rs1 ^ b_eff));
         eq_q <= o_eq;
      end
   end

endmodule

`default_nettype wire

// File: design/bsc_pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module bsc_pc_unit (
   input  wire                       clk,
   input  wire                       i_rst_n,
   input  wire  [bsc_pkg::cnt_w-1:0] i_cnt,
   input  wire                       i_exec_en,
   input  wire                       i_jump,
   input  wire                       i_imm,
   output logic [bsc_pkg::xlen-1:0]  o_ibus_adr,
   output logic                      o_link
);
   import bsc_pkg::*;

   logic [xlen-1:0] pc;
   logic nxt_c;
   logic lnk_c;
   logic first;
   logic incr_bit;
   logic nxt_b;
   logic nxt_cin;
   logic lnk_cin;
   logic nxt_bit;

   assign first = i_cnt == '0;
   assign incr_bit = nop_incr[i_cnt];

   // PC shifts right during exec, so pc[0] is always bit cnt of the old PC
   assign nxt_b = i_jump ? i_imm : incr_bit;
   assign nxt_cin = first ? 1'b0 : nxt_c;
   assign nxt_bit = pc[0] ^ nxt_b ^ nxt_cin;

   // Return address for JAL
   assign lnk_cin = first ? 1'b0 : lnk_c;
   assign o_link = pc[0] ^ incr_bit ^ lnk_cin;

   assign o_ibus_adr = pc;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc <= reset_pc;
         nxt_c <= 1'b0;
         lnk_c <= 1'b0;
      end else if (i_exec_en) begin
         pc <= {nxt_bit, pc[xlen-1:1]};
         nxt_c <= (pc[0] & nxt_b) | (nxt_cin & (pc[0] ^ nxt_b));
         lnk_c <= (pc[0] & incr_bit) | (lnk_cin & (pc[0] ^ incr_bit));
      end
   end

endmodule

`default_nettype wire

// File: design/bsc_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module bsc_regfile (
   input  wire                       clk,
   input  wire  [bsc_pkg::cnt_w-1:0] i_cnt,
   input  wire                       i_wen,
   input  wire  [4:0]                i_rd_addr,
   input  wire  [4:0]                i_rs1_addr,
   input  wire  [4:0]                i_rs2_addr,
   input  wire  bsc_pkg::rd_src_e    i_rd_src,
   input  wire                       i_alu_rd,
   input  wire                       i_link,
   input  wire                       i_imm,
   output logic                      o_rs1,
   output logic                      o_rs2
);
   import bsc_pkg::*;

   // x1..x31, x0 has no storage
   logic [xlen-1:0] regs [1:31];
   logic wr_bit;

   always_comb begin
      case (i_rd_src)
         rd_from_link: wr_bit = i_link;
         rd_from_imm:  wr_bit = i_imm;
         default:      wr_bit = i_alu_rd;
      endcase
   end

   assign o_rs1 = (i_rs1_addr == 5'd0) ? 1'b0 : regs[i_rs1_addr][i_cnt];
   assign o_rs2 = (i_rs2_addr == 5'd0) ? 1'b0 : regs[i_rs2_addr][i_cnt];

   // Old bit is read in the same cycle it gets overwritten
   always_ff @(posedge clk) begin
      if (i_wen && i_rd_addr != 5'd0) begin
         regs[i_rd_addr][i_cnt] <= wr_bit;
      end
   end

endmodule

`default_nettype wire

// File: design/bsc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module bsc_sequencer (
   input  wire                       clk,
   input  wire                       i_rst_n,
   input  wire                       i_ibus_ack,
   input  wire  bsc_pkg::op_class_e  i_class,
   input  wire                       i_bne,
   input  wire                       i_eq,
   input  wire                       i_store_done,
   output logic                      o_ibus_cyc,
   output logic [bsc_pkg::cnt_w-1:0] o_cnt,
   output logic                      o_cmp_en,
   output logic                      o_exec_en,
   output logic                      o_rd_wen,
   output logic                      o_pc_jump,
   output logic                      o_store_start
);
   import bsc_pkg::*;

   seq_state_e state;
   logic taken;
   logic last;
   logic is_branch;
   logic is_store;
   logic writes_rd;

   assign last = o_cnt == '1;
   assign is_branch = i_class == cls_branch;
   assign is_store = i_class == cls_store;
   assign writes_rd = i_class inside {cls_alu_reg, cls_alu_imm, cls_lui, cls_jal};

   // First pass after a fetch lives in st_compare, but only a branch compares there
   assign o_cmp_en = (state == st_compare) & is_branch;
   assign o_exec_en = (state == st_exec) | ((state == st_compare) & !is_branch);

   assign o_rd_wen = o_exec_en & writes_rd;
   assign o_pc_jump = o_exec_en & ((i_class == cls_jal) | (is_branch & taken));
   assign o_store_start = o_exec_en & last & is_store;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= st_fetch;
         o_cnt <= '0;
         o_ibus_cyc <= 1'b0;
         taken <= 1'b0;
      end else begin
         if (o_cmp_en | o_exec_en) begin
            o_cnt <= o_cnt + 1'b1;
         end
         case (state)
            st_fetch: begin
               if (o_ibus_cyc & i_ibus_ack) begin
                  o_ibus_cyc <= 1'b0;
                  state <= st_compare;
               end else begin
                  o_ibus_cyc <= 1'b1;
               end
            end
            st_store: begin
               if (i_store_done) begin
                  o_ibus_cyc <= 1'b1;
                  state <= st_fetch;
               end
            end
            default: begin
               if (o_exec_en & last) begin
                  if (is_store) begin
                     state <= st_store;
                  end else begin
                     o_ibus_cyc <= 1'b1;
                     state <= st_fetch;
                  end
               end else if (o_cmp_en & last) begin
                  // BEQ taken on equal, BNE on not equal
                  taken <= i_eq ^ i_bne;
                  state <= st_exec;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: design/bsc_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module bsc_store_unit (
   input  wire                       clk,
   input  wire                       i_rst_n,
   input  wire  [bsc_pkg::cnt_w-1:0] i_cnt,
   input  wire                       i_capture,
   input  wire                       i_addr_bit,
   input  wire                       i_data_bit,
   input  wire                       i_start,
   input  wire                       i_dbus_ack,
   output logic [bsc_pkg::xlen-1:0]  o_dbus_adr,
   output logic [bsc_pkg::xlen-1:0]  o_dbus_dat,
   output logic                      o_dbus_cyc,
   output logic                      o_done
);

   // Filled on every exec pass, only used after a store
   always_ff @(posedge clk) begin
      if (i_capture) begin
         o_dbus_adr[i_cnt] <= i_addr_bit;
         o_dbus_dat[i_cnt] <= i_data_bit;
      end
   end

   assign o_done = o_dbus_cyc & i_dbus_ack;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_dbus_cyc <= 1'b0;
      end else if (i_start) begin
         o_dbus_cyc <= 1'b1;
      end else if (o_done) begin
         o_dbus_cyc <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: design/bsc_top.sv
`timescale 1ns/1ps
`default_nettype none

module bsc_top (
   input  wire                      clk,
   input  wire                      i_rst_n,
   output logic [bsc_pkg::xlen-1:0] o_ibus_adr,
   output logic                     o_ibus_cyc,
   input  wire  [bsc_pkg::xlen-1:0] i_ibus_rdt,
   input  wire                      i_ibus_ack,
   output logic [bsc_pkg::xlen-1:0] o_dbus_adr,
   output logic [bsc_pkg::xlen-1:0] o_dbus_dat,
   output logic                     o_dbus_cyc,
   input  wire                      i_dbus_ack
);
   import bsc_pkg::*;

   logic [cnt_w-1:0] cnt;
   logic cmp_en;
   logic exec_en;
   logic rd_wen;
   logic pc_jump;
   logic store_start;
   logic store_done;
   logic eq;

   op_class_e op_class;
   alu_op_e alu_op;
   rd_src_e rd_src;
   logic op_b_imm;
   logic bne;
   logic [4:0] rd_addr;
   logic [4:0] rs1_addr;
   logic [4:0] rs2_addr;

   // Serial bit lanes
   logic imm;
   logic rs1;
   logic rs2;
   logic alu_rd;
   logic link_rd;

   bsc_sequencer u_seq (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_ibus_ack    (i_ibus_ack),
      .i_class       (op_class),
      .i_bne         (bne),
      .i_eq          (eq),
      .i_store_done  (store_done),
      .o_ibus_cyc    (o_ibus_cyc),
      .o_cnt         (cnt),
      .o_cmp_en      (cmp_en),
      .o_exec_en     (exec_en),
      .o_rd_wen      (rd_wen),
      .o_pc_jump     (pc_jump),
      .o_store_start (store_start)
   );

   bsc_decode u_decode (
      .clk        (clk),
      .i_rdt      (i_ibus_rdt),
      .i_en       (o_ibus_cyc & i_ibus_ack),
      .o_class    (op_class),
      .o_alu_op   (alu_op),
      .o_op_b_imm (op_b_imm),
      .o_bne      (bne),
      .o_rd_src   (rd_src),
      .o_rd_addr  (rd_addr),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr)
   );

   bsc_immdec u_immdec (
      .clk   (clk),
      .i_rdt (i_ibus_rdt),
      .i_en  (o_ibus_cyc & i_ibus_ack),
      .i_cnt (cnt),
      .o_imm (imm)
   );

   bsc_alu u_alu (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt      (cnt),
      .i_active   (cmp_en | exec_en),
      .i_rs1      (rs1),
      .i_rs2      (rs2),
      .i_imm      (imm),
      .i_op_b_imm (op_b_imm),
      .i_op       (alu_op),
      .o_rd       (alu_rd),
      .o_eq       (eq)
   );

   bsc_pc_unit u_pc (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt      (cnt),
      .i_exec_en  (exec_en),
      .i_jump     (pc_jump),
      .i_imm      (imm),
      .o_ibus_adr (o_ibus_adr),
      .o_link     (link_rd)
   );

   bsc_regfile u_rf (
      .clk        (clk),
      .i_cnt      (cnt),
      .i_wen      (rd_wen),
      .i_rd_addr  (rd_addr),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_src   (rd_src),
      .i_alu_rd   (alu_rd),
      .i_link     (link_rd),
      .i_imm      (imm),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   // Store address comes out of the ALU adder, data straight from rs2
   bsc_store_unit u_store (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt      (cnt),
      .i_capture  (exec_en),
      .i_addr_bit (alu_rd),
      .i_data_bit (rs2),
      .i_start    (store_start),
      .i_dbus_ack (i_dbus_ack),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_cyc (o_dbus_cyc),
      .o_done     (store_done)
   );

endmodule

`default_nettype wire

// File: project.f
common/bsc_pkg.sv
design/bsc_sequencer.sv
decoder/bsc_decode.sv
decoder/bsc_immdec.sv
design/bsc_alu.sv
design/bsc_pc_unit.sv
design/bsc_regfile.sv
design/bsc_store_unit.sv
design/bsc_top.sv
verification/bsc_properties.sv
verification/bsc_checker.sv
verification/bsc_tb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module bsc_tb -f project.f -o bsc_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/bsc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
   exit 0
fi
exit 1

// File: verification/bsc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bsc_checker (
   input  wire        clk,
   input  wire        i_rst_n,
   input  wire [31:0] i_ibus_adr,
   input  wire        i_ibus_cyc,
   input  wire [31:0] i_ibus_rdt,
   input  wire        i_ibus_ack,
   input  wire [31:0] i_dbus_adr,
   input  wire [31:0] i_dbus_dat,
   input  wire        i_dbus_cyc,
   input  wire        i_dbus_ack,
   input  wire [31:0] i_end_adr,
   output logic       o_done,
   output int         o_tests,
   output int         o_errors
);
   import bsc_pkg::*;

   logic [31:0] ref_regs [32];
   logic [31:0] ref_pc = reset_pc;
   logic store_due = 1'b0;
   logic store_seen = 1'b0;
   logic [31:0] exp_adr;
   logic [31:0] exp_dat;
   string cur_name = "reset";
   int test_errs = 0;
   int insn_idx = 0;
   int tests = 0;
   int errors = 0;
   logic done = 1'b0;

   assign o_done = done;
   assign o_tests = tests;
   assign o_errors = errors;

   initial begin
      for (int i = 0; i < 32; i++) begin
         ref_regs[i] = 32'h0;
      end
   end

   function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                           input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'b100: return a ^ b;
         3'b110: return a | b;
         3'b111: return a & b;
         default: return sub ? a - b : a + b;
      endcase
   endfunction

   // RV32I subset model, one instruction per call
   function automatic string step_model(input logic [31:0] w);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [31:0] nxt;
      logic [2:0] f3;
      logic f3_ok;
      logic wr;
      op_class_e cls;
      a = ref_regs[w[19:15]];
      b = ref_regs[w[24:20]];
      f3 = w[14:12];
      f3_ok = f3 inside {3'b000, 3'b100, 3'b110, 3'b111};
      res = 32'h0;
      wr = 1'b0;
      nxt = ref_pc + 32'd4;
      cls = cls_nop;
      case (w[6:0])
         7'b0110011: begin
            if (f3_ok && w[31:25] == 7'b0000000) begin
               cls = cls_alu_reg;
               res = alu_ref(f3, 1'b0, a, b);
               wr = 1'b1;
            end else if (f3 == 3'b000 && w[31:25] == 7'b0100000) begin
               cls = cls_alu_reg;
               res = alu_ref(f3, 1'b1, a, b);
               wr = 1'b1;
            end
         end
         7'b0010011: begin
            if (f3_ok) begin
               cls = cls_alu_imm;
               res = alu_ref(f3, 1'b0, a, {{20{w[31]}}, w[31:20]});
               wr = 1'b1;
            end
         end
         7'b0110111: begin
            cls = cls_lui;
            res = {w[31:12], 12'h000};
            wr = 1'b1;
         end
         7'b1101111: begin
            cls = cls_jal;
            res = ref_pc + 32'd4;
            wr = 1'b1;
            nxt = ref_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
         end
         7'b1100011: begin
            if (f3[2:1] == 2'b00) begin
               cls = cls_branch;
               // funct3 bit 0 turns BEQ into BNE
               if ((a == b) != f3[0]) begin
                  nxt = ref_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
               end
            end
         end
         7'b0100011: begin
            if (f3 == 3'b010) begin
               cls = cls_store;
               store_due = 1'b1;
               exp_adr = a + {{20{w[31]}}, w[31:25], w[11:7]};
               exp_dat = b;
            end
         end
         default: ;
      endcase
      if (wr && w[11:7] != 5'd0) begin
         ref_regs[w[11:7]] = res;
      end
      ref_pc = nxt;
      return $sformatf("insn%0d_%s", insn_idx, cls.name());
   endfunction

   task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("FAIL %s %s: expected %h, actual %h", cur_name, what, exp, act);
         errors++;
         test_errs++;
      end
   endtask

   task automatic report_error(input string why);
      $display("ERROR in %s: %s", cur_name, why);
      errors++;
      test_errs++;
   endtask

   always @(posedge clk) begin
      if (!i_rst_n) begin
         if (i_ibus_cyc || i_dbus_cyc) begin
            report_error("a bus cycle is active while reset is asserted");
         end
      end else if (!done) begin
         if (i_dbus_cyc && i_dbus_ack) begin
            if (!store_due || store_seen) begin
               report_error($sformatf("store to %h that the model does not expect", i_dbus_adr));
            end else begin
               check_val("store_adr", exp_adr, i_dbus_adr);
               check_val("store_dat", exp_dat, i_dbus_dat);
               store_seen = 1'b1;
            end
         end
         if (i_ibus_cyc && i_ibus_ack) begin
            if (store_due && !store_seen) begin
               report_error("the expected store never appeared on the data bus");
            end
            check_val("fetch_adr", ref_pc, i_ibus_adr);
            $display("test %-24s %s", cur_name, test_errs == 0 ? "ok" : "mismatch");
            tests++;
            if (i_ibus_adr >= i_end_adr) begin
               done = 1'b1;
            end else begin
               store_due = 1'b0;
               store_seen = 1'b0;
               test_errs = 0;
               insn_idx++;
               cur_name = step_model(i_ibus_rdt);
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: verification/bsc_properties.sv
`timescale 1ns/1ps
`default_nettype none

module bsc_properties (
   input wire        clk,
   input wire        i_rst_n,
   input wire [31:0] i_ibus_adr,
   input wire        i_ibus_cyc,
   input wire        i_ibus_ack,
   input wire        i_dbus_cyc
);

   // Fetch address held until the ack
   adr_stable_a: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ibus_cyc && !i_ibus_ack |=> $stable(i_ibus_adr))
      else $error("fetch address changed while waiting for ack");

   one_bus_a: assert property (@(posedge clk) !(i_ibus_cyc && i_dbus_cyc))
      else $error("instruction and data bus cycles overlap");

   reset_quiet_a: assert property (@(posedge clk) !i_rst_n |-> !i_ibus_cyc && !i_dbus_cyc)
      else $error("bus cycle active during reset");

endmodule

bind bsc_top bsc_properties props_i (
   .clk        (clk),
   .i_rst_n    (i_rst_n),
   .i_ibus_adr (o_ibus_adr),
   .i_ibus_cyc (o_ibus_cyc),
   .i_ibus_ack (i_ibus_ack),
   .i_dbus_cyc (o_dbus_cyc)
);

`default_nettype wire

// File: verification/bsc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bsc_tb;
   import bsc_pkg::*;

   localparam int mem_words = 128;
   localparam logic [31:0] prog_end = 32'd508;
   localparam int cyc_timeout = 300;
   localparam int run_timeout = 40000;

   logic clk;
   logic rst_n;
   logic [31:0] ibus_adr;
   logic ibus_cyc;
   logic [31:0] ibus_rdt;
   logic ibus_ack;
   logic [31:0] dbus_adr;
   logic [31:0] dbus_dat;
   logic dbus_cyc;
   logic dbus_ack;
   logic chk_done;
   int tests;
   int errors;

   logic [31:0] imem [mem_words];
   integer seed = 32'h51aa;
   logic hang = 1'b0;
   string hang_why;

   bsc_top dut_i (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_dbus_adr (dbus_adr),
      .o_dbus_dat (dbus_dat),
      .o_dbus_cyc (dbus_cyc),
      .i_dbus_ack (dbus_ack)
   );

   bsc_checker chk_i (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .i_ibus_adr (ibus_adr),
      .i_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .i_dbus_adr (dbus_adr),
      .i_dbus_dat (dbus_dat),
      .i_dbus_cyc (dbus_cyc),
      .i_dbus_ack (dbus_ack),
      .i_end_adr  (prog_end),
      .o_done     (chk_done),
      .o_tests    (tests),
      .o_errors   (errors)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [2:0] alu_funct3(input logic [1:0] sel);
      case (sel)
         2'd0: return 3'b000;
         2'd1: return 3'b100;
         2'd2: return 3'b110;
         default: return 3'b111;
      endcase
   endfunction

   task automatic build_program();
      logic [31:0] r;
      logic [2:0] f3;
      logic [4:0] rs2;
      logic [11:0] ofs;
      for (int i = 0; i < mem_words; i++) begin
         imem[i] = 32'h0;
      end
      // Give x1..x31 known starting values
      for (int i = 1; i < 32; i++) begin
         r = $random(seed);
         imem[i-1] = {r[31:20], 5'd0, 3'b000, 5'(i), opc_imm};
      end
      // Forward jumps and branches all land before the final stores
      for (int i = 31; i < 93; i++) begin
         r = $random(seed);
         f3 = alu_funct3(r[13:12]);
         // Half the branches compare a register with itself
         rs2 = r[25] ? r[19:15] : r[24:20];
         ofs = {2'b00, r[9:2], 2'b00};
         case (i % 8)
            0, 2: imem[i] = {1'b0, (f3 == 3'b000) & r[30], 5'd0, r[24:15], f3, r[11:7], opc_reg};
            1: imem[i] = {r[31:15], f3, r[11:7], opc_imm};
            3: imem[i] = {r[31:7], opc_lui};
            4: imem[i] = {8'h00, 1'b1, r[2], 2'b00, 8'h00, r[11:7], opc_jal};
            5: imem[i] = {7'd0, rs2, r[19:15], 2'b00, r[12], 1'b1, r[2], 2'b00, 1'b0, opc_branch};
            6: imem[i] = {ofs[11:5], r[24:20], 5'd0, 3'b010, ofs[4:0], opc_store};
            default: imem[i] = {r[31:7], 7'b0000011};
         endcase
      end
      imem[40] = {12'h5a5, 5'd0, 3'b000, 5'd0, opc_imm};
      // Every register ends up on the data bus, x0 too
      for (int k = 0; k < 32; k++) begin
         ofs = 12'h200 + 12'(k * 4);
         imem[95 + k] = {ofs[11:5], 5'(k), 5'd0, 3'b010, ofs[4:0], opc_store};
      end
   endtask

   initial begin : ibus_responder
      int waited;
      int delay;
      ibus_ack = 1'b0;
      ibus_rdt = 32'h0;
      while (!hang) begin
         waited = 0;
         @(negedge clk);
         while (!ibus_cyc && waited < cyc_timeout) begin
            @(negedge clk);
            waited++;
         end
         if (!ibus_cyc) begin
            hang_why = $sformatf("no instruction fetch seen for %0d cycles", cyc_timeout);
            hang = 1'b1;
         end else begin
            delay = $random(seed) & 3;
            repeat (delay) @(negedge clk);
            ibus_rdt = imem[ibus_adr[8:2]];
            ibus_ack = 1'b1;
            @(negedge clk);
            ibus_ack = 1'b0;
         end
      end
   end

   initial begin : dbus_responder
      int delay;
      dbus_ack = 1'b0;
      forever begin
         @(negedge clk);
         if (dbus_cyc) begin
            delay = $random(seed) & 3;
            repeat (delay) @(negedge clk);
            dbus_ack = 1'b1;
            @(negedge clk);
            dbus_ack = 1'b0;
         end
      end
   end

   initial begin : main_sequence
      int waited;
      rst_n = 1'b0;
      build_program();
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      waited = 0;
      while (!chk_done && !hang && waited < run_timeout) begin
         @(negedge clk);
         waited++;
      end
      if (hang) begin
         $display("%s", hang_why);
      end else if (!chk_done) begin
         $display("program did not reach its end within %0d cycles", run_timeout);
      end
      $display("tests run: %0d, errors: %0d", tests, errors);
      if (chk_done && !hang && errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
